//--- verilog/opn_pkg.sv
package opn_pkg;

	// ------------------------------
	// widths with a meaning
	// ------------------------------

	typedef logic [7:0] bus_byte_t;   // host data and register addresses.
	typedef logic [9:0] timer_a_t;    // timer A load value.
	typedef logic [7:0] timer_b_t;    // timer B load value.
	typedef logic [3:0] lfo_t;        // enable bit on top of a 3 bit rate.
	typedef logic [2:0] kon_ch_t;
	typedef logic [3:0] kon_slot_t;

	// ------------------------------
	// global register map
	// ------------------------------

	localparam bus_byte_t ADDR_LFO   = 8'h22;
	localparam bus_byte_t ADDR_TA_HI = 8'h24;   // value bits 9..2.
	localparam bus_byte_t ADDR_TA_LO = 8'h25;   // value bits 1..0.
	localparam bus_byte_t ADDR_TB    = 8'h26;
	localparam bus_byte_t ADDR_TCTRL = 8'h27;
	localparam bus_byte_t ADDR_KON   = 8'h28;

	// fields of the timer control register.
	localparam int TCTRL_LOAD_A = 0;
	localparam int TCTRL_LOAD_B = 1;
	localparam int TCTRL_EN_A   = 2;
	localparam int TCTRL_EN_B   = 3;
	localparam int TCTRL_RST_A  = 4;
	localparam int TCTRL_RST_B  = 5;

	// timer B advances once for every 16 host ticks.
	localparam int TIMER_B_PRESCALE = 16;

endpackage

//--- verilog/opn_host_if.sv
`timescale 1ns/1ns

module opn_host_if
	(
	input  logic               mclk,
	input  logic               rst_i,
	input  logic               bus_req_i,
	input  logic               bus_a0_i,
	input  opn_pkg::bus_byte_t bus_data_i,
	output logic               bus_ack_o,
	output opn_pkg::bus_byte_t sel_addr_o,
	output opn_pkg::bus_byte_t wr_data_o,
	output logic               wr_stb_o
	);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACK,
		ST_RELEASE
	} state_t;

	state_t             state_q;
	state_t             state_d;
	logic               is_data_q;
	opn_pkg::bus_byte_t sel_addr_q;
	opn_pkg::bus_byte_t wr_data_q;
	logic               accept;

	assign accept = (state_q == ST_IDLE) && bus_req_i;

	// ------------------------------
	// four-phase handshake
	// ------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (bus_req_i)
					state_d = ST_ACK;
			end
			ST_ACK: begin
				// the strobe cycle lasts exactly one clock.
				if (bus_req_i)
					state_d = ST_RELEASE;
				else
					state_d = ST_IDLE;
			end
			ST_RELEASE: begin
				if (!bus_req_i)
					state_d = ST_IDLE;
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge mclk) begin
		if (rst_i)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	always_ff @(posedge mclk) begin
		if (rst_i) begin
			sel_addr_q <= '0;
			is_data_q  <= 1'b0;
		end else if (accept) begin
			is_data_q <= bus_a0_i;
			if (!bus_a0_i)
				sel_addr_q <= bus_data_i;   // address stays until the next address transfer.
		end
	end

	always_ff @(posedge mclk) begin
		if (accept && bus_a0_i)
			wr_data_q <= bus_data_i;
	end

	assign bus_ack_o  = (state_q != ST_IDLE);
	assign wr_stb_o   = (state_q == ST_ACK) && is_data_q;
	assign sel_addr_o = sel_addr_q;
	assign wr_data_o  = wr_data_q;

	// ------------------------------
	// protocol checks
	// ------------------------------

	ack_needs_req: assert property (@(posedge mclk) disable iff (rst_i)
		$rose(bus_ack_o) |-> $past(bus_req_i));

	stb_one_cycle: assert property (@(posedge mclk) disable iff (rst_i)
		wr_stb_o |=> !wr_stb_o);

endmodule

//--- verilog/opn_global_regs.sv
`timescale 1ns/1ns

module opn_global_regs
	(
	input  logic                mclk,
	input  logic                rst_i,
	input  opn_pkg::bus_byte_t  sel_addr_i,
	input  opn_pkg::bus_byte_t  wr_data_i,
	input  logic                wr_stb_i,
	output opn_pkg::lfo_t       lfo_o,
	output opn_pkg::kon_ch_t    kon_ch_o,
	output opn_pkg::kon_slot_t  kon_slot_o,
	output opn_pkg::timer_a_t   ta_val_o,
	output logic                ta_run_o,
	output logic                ta_en_o,
	output logic                ta_clr_o,
	output opn_pkg::timer_b_t   tb_val_o,
	output logic                tb_run_o,
	output logic                tb_en_o,
	output logic                tb_clr_o
	);

	opn_pkg::lfo_t      lfo_q;
	opn_pkg::kon_ch_t   kon_ch_q;
	opn_pkg::kon_slot_t kon_slot_q;
	opn_pkg::timer_a_t  ta_val_q;
	opn_pkg::timer_b_t  tb_val_q;
	logic               ta_run_q;
	logic               ta_en_q;
	logic               tb_run_q;
	logic               tb_en_q;
	logic               ta_clr_q;
	logic               tb_clr_q;
	logic               tctrl_wr;

	assign tctrl_wr = wr_stb_i && (sel_addr_i == opn_pkg::ADDR_TCTRL);

	// ------------------------------
	// register storage
	// ------------------------------

	always_ff @(posedge mclk) begin
		if (rst_i) begin
			lfo_q      <= '0;
			kon_ch_q   <= '0;
			kon_slot_q <= '0;
			ta_val_q   <= '0;
			tb_val_q   <= '0;
			ta_run_q   <= 1'b0;
			ta_en_q    <= 1'b0;
			tb_run_q   <= 1'b0;
			tb_en_q    <= 1'b0;
		end else if (wr_stb_i) begin
			case (sel_addr_i)
				opn_pkg::ADDR_LFO:   lfo_q <= wr_data_i[3:0];
				opn_pkg::ADDR_TA_HI: ta_val_q[9:2] <= wr_data_i;
				opn_pkg::ADDR_TA_LO: ta_val_q[1:0] <= wr_data_i[1:0];
				opn_pkg::ADDR_TB:    tb_val_q <= wr_data_i;
				opn_pkg::ADDR_TCTRL: begin
					ta_run_q <= wr_data_i[opn_pkg::TCTRL_LOAD_A];
					tb_run_q <= wr_data_i[opn_pkg::TCTRL_LOAD_B];
					ta_en_q  <= wr_data_i[opn_pkg::TCTRL_EN_A];
					tb_en_q  <= wr_data_i[opn_pkg::TCTRL_EN_B];
				end
				opn_pkg::ADDR_KON: begin
					kon_ch_q   <= wr_data_i[2:0];
					kon_slot_q <= wr_data_i[7:4];
				end
				default: ;   // unused addresses are ignored.
			endcase
		end
	end

	// the reset bits of 0x27 are not stored, they only fire once.
	always_ff @(posedge mclk) begin
		if (rst_i) begin
			ta_clr_q <= 1'b0;
			tb_clr_q <= 1'b0;
		end else begin
			ta_clr_q <= tctrl_wr && wr_data_i[opn_pkg::TCTRL_RST_A];
			tb_clr_q <= tctrl_wr && wr_data_i[opn_pkg::TCTRL_RST_B];
		end
	end

	assign lfo_o      = lfo_q;
	assign kon_ch_o   = kon_ch_q;
	assign kon_slot_o = kon_slot_q;
	assign ta_val_o   = ta_val_q;
	assign ta_run_o   = ta_run_q;
	assign ta_en_o    = ta_en_q;
	assign ta_clr_o   = ta_clr_q;
	assign tb_val_o   = tb_val_q;
	assign tb_run_o   = tb_run_q;
	assign tb_en_o    = tb_en_q;
	assign tb_clr_o   = tb_clr_q;

endmodule

//--- verilog/opn_timer.sv
`timescale 1ns/1ns

module opn_timer
	#(
	parameter int CNT_W    = 10,
	parameter int PRESCALE = 1
	)
	(
	input  logic             mclk,
	input  logic             rst_i,
	input  logic             tick_i,
	input  logic [CNT_W-1:0] load_val_i,
	input  logic             run_i,
	input  logic             en_i,
	input  logic             clr_i,
	output logic             status_o
	);

	logic [CNT_W-1:0] cnt_q;
	logic             count_en;
	logic             ovf;
	logic             status_q;

	// ------------------------------
	// tick prescaler
	// ------------------------------

	generate
		if (PRESCALE > 1) begin : g_prescale
			localparam int PS_W = $clog2(PRESCALE);

			logic [PS_W-1:0] ps_q;
			logic            ps_wrap;

			assign ps_wrap = (ps_q == PS_W'(PRESCALE - 1));

			// held at zero while stopped so the first period is exact.
			always_ff @(posedge mclk) begin
				if (rst_i || !run_i)
					ps_q <= '0;
				else if (tick_i) begin
					if (ps_wrap)
						ps_q <= '0;
					else
						ps_q <= ps_q + 1'b1;
				end
			end

			assign count_en = run_i && tick_i && ps_wrap;
		end else begin : g_direct
			assign count_en = run_i && tick_i;
		end
	endgenerate

	// ------------------------------
	// counter and status flag
	// ------------------------------

	assign ovf = count_en && (cnt_q == {CNT_W{1'b1}});

	always_ff @(posedge mclk) begin
		if (rst_i)
			cnt_q <= '0;
		else if (!run_i || ovf)
			cnt_q <= load_val_i;   // reload on overflow as well as while stopped.
		else if (count_en)
			cnt_q <= cnt_q + 1'b1;
	end

	always_ff @(posedge mclk) begin
		if (rst_i || clr_i)
			status_q <= 1'b0;
		else if (ovf && en_i)
			status_q <= 1'b1;
	end

	assign status_o = status_q;

	// a new status flag always comes from a running, enabled timer.
	status_from_run: assert property (@(posedge mclk) disable iff (rst_i)
		$rose(status_o) |-> $past(run_i && en_i));

endmodule

//--- verilog/opn_reg_top.sv
`timescale 1ns/1ns

module opn_reg_top
	(
	input  logic               mclk,
	input  logic               rst_i,
	input  logic               bus_req_i,
	input  logic               bus_a0_i,
	input  opn_pkg::bus_byte_t bus_data_i,
	input  logic               tick_i,
	output logic               bus_ack_o,
	output opn_pkg::lfo_t      lfo_o,
	output opn_pkg::kon_ch_t   kon_ch_o,
	output opn_pkg::kon_slot_t kon_slot_o,
	output logic               timer_a_status_o,
	output logic               timer_b_status_o
	);

	opn_pkg::bus_byte_t sel_addr;
	opn_pkg::bus_byte_t wr_data;
	logic               wr_stb;

	opn_pkg::timer_a_t  ta_val;
	logic               ta_run;
	logic               ta_en;
	logic               ta_clr;
	opn_pkg::timer_b_t  tb_val;
	logic               tb_run;
	logic               tb_en;
	logic               tb_clr;

	opn_host_if u_host (
		.mclk       (mclk),
		.rst_i      (rst_i),
		.bus_req_i  (bus_req_i),
		.bus_a0_i   (bus_a0_i),
		.bus_data_i (bus_data_i),
		.bus_ack_o  (bus_ack_o),
		.sel_addr_o (sel_addr),
		.wr_data_o  (wr_data),
		.wr_stb_o   (wr_stb)
	);

	opn_global_regs u_regs (
		.mclk       (mclk),
		.rst_i      (rst_i),
		.sel_addr_i (sel_addr),
		.wr_data_i  (wr_data),
		.wr_stb_i   (wr_stb),
		.lfo_o      (lfo_o),
		.kon_ch_o   (kon_ch_o),
		.kon_slot_o (kon_slot_o),
		.ta_val_o   (ta_val),
		.ta_run_o   (ta_run),
		.ta_en_o    (ta_en),
		.ta_clr_o   (ta_clr),
		.tb_val_o   (tb_val),
		.tb_run_o   (tb_run),
		.tb_en_o    (tb_en),
		.tb_clr_o   (tb_clr)
	);

	// timer A counts every host tick.
	opn_timer #(.CNT_W($bits(opn_pkg::timer_a_t)), .PRESCALE(1)) u_timer_a (
		.mclk       (mclk),
		.rst_i      (rst_i),
		.tick_i     (tick_i),
		.load_val_i (ta_val),
		.run_i      (ta_run),
		.en_i       (ta_en),
		.clr_i      (ta_clr),
		.status_o   (timer_a_status_o)
	);

	opn_timer #(
		.CNT_W    ($bits(opn_pkg::timer_b_t)),
		.PRESCALE (opn_pkg::TIMER_B_PRESCALE)
	) u_timer_b (
		.mclk       (mclk),
		.rst_i      (rst_i),
		.tick_i     (tick_i),
		.load_val_i (tb_val),
		.run_i      (tb_run),
		.en_i       (tb_en),
		.clr_i      (tb_clr),
		.status_o   (timer_b_status_o)
	);

endmodule

//--- include/opn_tb_ref.svh
`ifndef OPN_TB_REF_SVH
`define OPN_TB_REF_SVH

// ------------------------------
// timer periods in host ticks
// ------------------------------

// timer A overflows once it has counted from N up through all ones.
function automatic int timer_a_ticks(input opn_pkg::timer_a_t n);
	return 1024 - int'(n);
endfunction

// timer B counts once per 16 ticks, from N up through all ones.
function automatic int timer_b_ticks(input opn_pkg::timer_b_t n);
	return opn_pkg::TIMER_B_PRESCALE * (256 - int'(n));
endfunction

// ------------------------------
// compare tasks
// ------------------------------

task automatic check_lfo(input opn_pkg::lfo_t exp, input opn_pkg::lfo_t act);
	if (act !== exp) begin
		$display("[ERROR] lfo_o expected 0x%h actual 0x%h", exp, act);
		$display("Checks failed");
		$fatal(1);
	end
endtask

task automatic check_kon_ch(input opn_pkg::kon_ch_t exp, input opn_pkg::kon_ch_t act);
	if (act !== exp) begin
		$display("[ERROR] kon_ch_o expected 0x%h actual 0x%h", exp, act);
		$display("Checks failed");
		$fatal(1);
	end
endtask

task automatic check_kon_slot(input opn_pkg::kon_slot_t exp, input opn_pkg::kon_slot_t act);
	if (act !== exp) begin
		$display("[ERROR] kon_slot_o expected 0x%h actual 0x%h", exp, act);
		$display("Checks failed");
		$fatal(1);
	end
endtask

task automatic check_status(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
		$display("Checks failed");
		$fatal(1);
	end
endtask

`endif

//--- dv/opn_reg_tb.sv
`timescale 1ns/1ns

module opn_reg_tb;

	localparam int TICK_CYCLES   = 4;
	localparam int ACK_WAIT      = 8;      // cycles allowed for each handshake edge.
	localparam int STOPPED_TICKS = 64;
	localparam int MARGIN_CYCLES = 4000;

	logic               mclk = 1'b0;
	logic               rst_i;
	logic               bus_req_i;
	logic               bus_a0_i;
	opn_pkg::bus_byte_t bus_data_i;
	logic               tick_i;
	logic               bus_ack_o;
	opn_pkg::lfo_t      lfo_o;
	opn_pkg::kon_ch_t   kon_ch_o;
	opn_pkg::kon_slot_t kon_slot_o;
	logic               timer_a_status_o;
	logic               timer_b_status_o;

	integer             seed;
	logic [31:0]        rnd;
	int                 tick_count;
	int                 tick_mark;     // tick count on the edge that ended the last data write.
	int                 watch_cycles;
	opn_pkg::timer_a_t  ta_n;
	opn_pkg::timer_a_t  ta_short;
	opn_pkg::timer_b_t  tb_n;
	int                 ta_period;
	int                 tb_period;
	int                 short_period;
	opn_pkg::bus_byte_t data;
	opn_pkg::lfo_t      exp_lfo;
	opn_pkg::kon_ch_t   exp_kon_ch;
	opn_pkg::kon_slot_t exp_kon_slot;

	opn_reg_top u_dut (
		.mclk             (mclk),
		.rst_i            (rst_i),
		.bus_req_i        (bus_req_i),
		.bus_a0_i         (bus_a0_i),
		.bus_data_i       (bus_data_i),
		.tick_i           (tick_i),
		.bus_ack_o        (bus_ack_o),
		.lfo_o            (lfo_o),
		.kon_ch_o         (kon_ch_o),
		.kon_slot_o       (kon_slot_o),
		.timer_a_status_o (timer_a_status_o),
		.timer_b_status_o (timer_b_status_o)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	`include "opn_tb_ref.svh"

	always #50 mclk = ~mclk;

	// one tick every 4 cycles, counted on the edge where the DUT samples it.
	initial begin
		tick_i     = 1'b0;
		tick_count = 0;
		forever begin
			repeat (TICK_CYCLES - 1) @(posedge mclk);
			tick_i <= 1'b1;
			@(posedge mclk);
			tick_i     <= 1'b0;
			tick_count <= tick_count + 1;
		end
	end

	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge mclk);
		abort_run("timeout: the watchdog expired before the test sequence finished");
	end

	// ------------------------------
	// bus driver
	// ------------------------------

	task automatic bus_write(input logic a0, input opn_pkg::bus_byte_t wdata);
		int waited;
		@(posedge mclk);
		bus_req_i  <= 1'b1;
		bus_a0_i   <= a0;
		bus_data_i <= wdata;
		waited = 0;
		@(negedge mclk);
		while (!bus_ack_o && waited < ACK_WAIT) begin
			@(negedge mclk);
			waited++;
		end
		if (!bus_ack_o)
			abort_run("bus_ack_o never rose after a request");
		@(posedge mclk);
		bus_req_i <= 1'b0;
		@(negedge mclk);
		tick_mark = tick_count;   // register outputs changed on the edge just passed.
		waited = 0;
		while (bus_ack_o && waited < ACK_WAIT) begin
			@(negedge mclk);
			waited++;
		end
		if (bus_ack_o)
			abort_run("bus_ack_o never fell after the request was dropped");
	endtask

	task automatic reg_write(input opn_pkg::bus_byte_t addr, input opn_pkg::bus_byte_t wdata);
		bus_write(1'b0, addr);
		bus_write(1'b1, wdata);
	endtask

	function automatic opn_pkg::bus_byte_t tctrl_byte(input logic load_a, input logic load_b,
		input logic en_a, input logic en_b, input logic rst_a, input logic rst_b);
		opn_pkg::bus_byte_t b;
		b = '0;
		b[opn_pkg::TCTRL_LOAD_A] = load_a;
		b[opn_pkg::TCTRL_LOAD_B] = load_b;
		b[opn_pkg::TCTRL_EN_A]   = en_a;
		b[opn_pkg::TCTRL_EN_B]   = en_b;
		b[opn_pkg::TCTRL_RST_A]  = rst_a;
		b[opn_pkg::TCTRL_RST_B]  = rst_b;
		return b;
	endfunction

	function automatic logic timer_status(input logic is_b);
		return is_b ? timer_b_status_o : timer_a_status_o;
	endfunction

	// ------------------------------
	// timer waits
	// ------------------------------

	// status must stay low until the last tick of the period, then rise within slack cycles.
	task automatic expect_overflow(input string name, input logic is_b, input int period,
		input int slack);
		int spins;
		while (tick_count - tick_mark < period) begin
			check_status(name, 1'b0, timer_status(is_b));
			@(negedge mclk);
		end
		spins = 0;
		while (!timer_status(is_b) && spins < slack) begin
			@(negedge mclk);
			spins++;
		end
		check_status(name, 1'b1, timer_status(is_b));
	endtask

	task automatic expect_rise_within(input string name, input logic is_b, input int ticks);
		int start;
		start = tick_count;
		while (!timer_status(is_b) && tick_count - start <= ticks)
			@(negedge mclk);
		check_status(name, 1'b1, timer_status(is_b));
	endtask

	task automatic statuses_stay_low(input int ticks);
		int start;
		start = tick_count;
		while (tick_count - start < ticks) begin
			check_status("timer_a_status_o", 1'b0, timer_a_status_o);
			check_status("timer_b_status_o", 1'b0, timer_b_status_o);
			@(negedge mclk);
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		rst_i        = 1'b1;
		bus_req_i    = 1'b0;
		bus_a0_i     = 1'b0;
		bus_data_i   = '0;
		tick_mark    = 0;
		watch_cycles = 0;
		seed         = 32'hd7a9_b49f;
		rnd          = $random(seed);
		ta_n         = {6'd0, rnd[3:0]};
		tb_n         = 8'd250 + {6'd0, rnd[5:4]};
		ta_short     = 10'd1016;
		ta_period    = timer_a_ticks(ta_n);
		tb_period    = timer_b_ticks(tb_n);
		short_period = timer_a_ticks(ta_short);
		watch_cycles = (ta_period + tb_period + 5 * short_period + STOPPED_TICKS)
			* TICK_CYCLES + MARGIN_CYCLES;

		repeat (16) @(posedge mclk);
		rst_i <= 1'b0;
		@(negedge mclk);
		check_status("bus_ack_o", 1'b0, bus_ack_o);
		check_status("timer_a_status_o", 1'b0, timer_a_status_o);
		check_status("timer_b_status_o", 1'b0, timer_b_status_o);
		check_lfo('0, lfo_o);
		check_kon_ch('0, kon_ch_o);
		check_kon_slot('0, kon_slot_o);

		// register writes, then a second data byte on the same address.
		rnd = $random(seed);
		data = rnd[7:0];
		reg_write(opn_pkg::ADDR_LFO, data);
		exp_lfo = data[3:0];
		check_lfo(exp_lfo, lfo_o);
		data = rnd[15:8];
		reg_write(opn_pkg::ADDR_KON, data);
		exp_kon_ch   = data[2:0];
		exp_kon_slot = data[7:4];
		check_kon_ch(exp_kon_ch, kon_ch_o);
		check_kon_slot(exp_kon_slot, kon_slot_o);
		data = ~data;   // every field differs from the byte before.
		bus_write(1'b1, data);
		exp_kon_ch   = data[2:0];
		exp_kon_slot = data[7:4];
		check_kon_ch(exp_kon_ch, kon_ch_o);
		check_kon_slot(exp_kon_slot, kon_slot_o);
		reg_write(8'h23, ~data);
		reg_write(8'h29, rnd[31:24]);
		check_lfo(exp_lfo, lfo_o);
		check_kon_ch(exp_kon_ch, kon_ch_o);
		check_kon_slot(exp_kon_slot, kon_slot_o);

		// timer A from a random load value.
		reg_write(opn_pkg::ADDR_TA_HI, ta_n[9:2]);
		reg_write(opn_pkg::ADDR_TA_LO, {6'd0, ta_n[1:0]});
		reg_write(opn_pkg::ADDR_TCTRL, tctrl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1));
		expect_overflow("timer_a_status_o", 1'b0, ta_period, 2);

		// timer B over its exact period while timer A is stopped and cleared.
		reg_write(opn_pkg::ADDR_TB, tb_n);
		reg_write(opn_pkg::ADDR_TCTRL, tctrl_byte(1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0));
		check_status("timer_a_status_o", 1'b0, timer_a_status_o);
		expect_overflow("timer_b_status_o", 1'b1, tb_period, 0);

		// clear while running, then disabled overflows, then a stopped timer.
		reg_write(opn_pkg::ADDR_TA_HI, ta_short[9:2]);
		reg_write(opn_pkg::ADDR_TA_LO, {6'd0, ta_short[1:0]});
		reg_write(opn_pkg::ADDR_TCTRL, tctrl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1));
		check_status("timer_b_status_o", 1'b0, timer_b_status_o);
		expect_overflow("timer_a_status_o", 1'b0, short_period, 2);
		reg_write(opn_pkg::ADDR_TCTRL, tctrl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
		check_status("timer_a_status_o", 1'b0, timer_a_status_o);
		expect_rise_within("timer_a_status_o", 1'b0, short_period + 1);
		reg_write(opn_pkg::ADDR_TCTRL, tctrl_byte(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
		statuses_stay_low(3 * short_period);
		reg_write(opn_pkg::ADDR_TCTRL, tctrl_byte(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1));
		statuses_stay_low(STOPPED_TICKS);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
verilog/opn_pkg.sv
verilog/opn_host_if.sv
verilog/opn_global_regs.sv
verilog/opn_timer.sv
verilog/opn_reg_top.sv
dv/opn_reg_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := opn_reg_tb
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
